// ==== control_unit.f ====
+incdir+src
+incdir+testbench
src/control_unit_pkg.sv
src/opcode_decoder.sv
src/state_sequencer.sv
src/datapath_control.sv
src/control_unit.sv
testbench/tb_control_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_control_unit \
    -f control_unit.f -o tb_control_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_control_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== src/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        memory_response,
    input  control_unit_pkg::opcode_t   instruction_opcode,
    output control_unit_pkg::pc_ctrl_t  pc_ctrl,
    output control_unit_pkg::mem_ctrl_t mem_ctrl,
    output control_unit_pkg::alu_ctrl_t alu_ctrl,
    output control_unit_pkg::wb_ctrl_t  wb_ctrl
);

    import control_unit_pkg::*;

    instr_class_t instr_class;
    cu_state_t    state;

    opcode_decoder u_opcode_decoder (
        .instruction_opcode (instruction_opcode),
        .instr_class        (instr_class)
    );

    state_sequencer u_state_sequencer (
        .clk             (clk),
        .reset           (reset),
        .memory_response (memory_response),
        .instr_class     (instr_class),
        .state           (state)
    );

    // Control word is a pure function of the state
    datapath_control u_datapath_control (
        .state    (state),
        .pc_ctrl  (pc_ctrl),
        .mem_ctrl (mem_ctrl),
        .alu_ctrl (alu_ctrl),
        .wb_ctrl  (wb_ctrl)
    );

endmodule

// ==== src/control_unit_pkg.sv ====
package control_unit_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] src_a_t; // Wider than needed to fit the datapath muxes
    typedef logic [2:0] src_b_t;
    typedef logic [2:0] wb_sel_t;
    typedef logic [1:0] addr_sel_t;
    typedef logic [1:0] aluop_t;

    typedef enum logic [3:0] {
        CLASS_LOAD, CLASS_STORE, CLASS_RTYPE, CLASS_ITYPE, CLASS_JAL, CLASS_BRANCH,
        CLASS_JALR, CLASS_AUIPC, CLASS_LUI, CLASS_CSR, CLASS_ILLEGAL
    } instr_class_t;

    typedef enum logic [4:0] {
        FETCH, VALIDATE_FETCH, DECODE, MEMADR, MEMREAD, MEMWB, MEMWRITE, EXECUTER,
        EXECUTEI, ALUWB, JAL, JALR_PC, JALR, BRANCH, AUIPC, LUI, EXECUTECSR
    } cu_state_t;

    typedef struct packed {
        logic pc_write;
        logic pc_write_cond; // PC written only if the branch is taken
        logic pc_source;
    } pc_ctrl_t;

    typedef struct packed {
        logic      memory_read;
        logic      memory_write;
        logic      ir_write;
        logic      save_address;
        addr_sel_t lord; // Instruction or data address
    } mem_ctrl_t;

    typedef struct packed {
        src_a_t alu_src_a;
        src_b_t alu_src_b;
        aluop_t aluop;
        logic   is_immediate;
    } alu_ctrl_t;

    typedef struct packed {
        logic    reg_write;
        wb_sel_t memory_to_reg;
        logic    csr_write_enable;
    } wb_ctrl_t;

endpackage

// ==== src/control_unit_settings.svh ====
`ifndef CONTROL_UNIT_SETTINGS_SVH
`define CONTROL_UNIT_SETTINGS_SVH

// RISC-V major opcodes taken from bits [6:0] of the instruction word
`define OP_LOAD    7'b0000011
`define OP_STORE   7'b0100011
`define OP_RTYPE   7'b0110011
`define OP_ITYPE   7'b0010011
`define OP_JAL     7'b1101111
`define OP_BRANCH  7'b1100011
`define OP_JALR    7'b1100111
`define OP_AUIPC   7'b0010111
`define OP_LUI     7'b0110111
`define OP_SYSTEM  7'b1110011 // CSR instructions live here

// ALU operand A sources
`define SRC_A_PC      3'd0
`define SRC_A_RS1     3'd1
`define SRC_A_OLD_PC  3'd2 // PC of the instruction being executed
`define SRC_A_ZERO    3'd3

// ALU operand B sources
`define SRC_B_RS2   3'd0
`define SRC_B_FOUR  3'd1
`define SRC_B_IMM   3'd2

// Register file write-back sources
`define WB_ALU_OUT   3'd0
`define WB_MEM_DATA  3'd1
`define WB_CSR_DATA  3'd2

// Memory address sources
`define ADDR_PC     2'd0
`define ADDR_SAVED  2'd2 // Address latched in MEMADR

// ALU operation classes handed to the ALU control
`define ALUOP_ADD     2'd0
`define ALUOP_BRANCH  2'd1
`define ALUOP_FUNCT   2'd2 // Operation taken from funct3/funct7

`endif

// ==== src/datapath_control.sv ====
`timescale 1ns/1ps

`include "control_unit_settings.svh"

module datapath_control (
    input  control_unit_pkg::cu_state_t state,
    output control_unit_pkg::pc_ctrl_t  pc_ctrl,
    output control_unit_pkg::mem_ctrl_t mem_ctrl,
    output control_unit_pkg::alu_ctrl_t alu_ctrl,
    output control_unit_pkg::wb_ctrl_t  wb_ctrl
);

    import control_unit_pkg::*;

    always_comb begin
        pc_ctrl.pc_write       = 1'b0;
        pc_ctrl.pc_write_cond  = 1'b0;
        pc_ctrl.pc_source      = 1'b0;
        mem_ctrl.memory_read   = 1'b0;
        mem_ctrl.memory_write  = 1'b0;
        mem_ctrl.ir_write      = 1'b0;
        mem_ctrl.save_address  = 1'b0;
        mem_ctrl.lord          = `ADDR_PC;
        alu_ctrl.alu_src_a     = `SRC_A_PC;
        alu_ctrl.alu_src_b     = `SRC_B_RS2;
        alu_ctrl.aluop         = `ALUOP_ADD;
        alu_ctrl.is_immediate  = 1'b0;
        wb_ctrl.reg_write      = 1'b0;
        wb_ctrl.memory_to_reg  = `WB_ALU_OUT;
        wb_ctrl.csr_write_enable = 1'b0;

        case (state)
            FETCH: begin
                mem_ctrl.memory_read = 1'b1;
            end
            VALIDATE_FETCH: begin
                mem_ctrl.memory_read = 1'b1;
                mem_ctrl.ir_write    = 1'b1;
                pc_ctrl.pc_write     = 1'b1; // PC + 4 from the ALU
                alu_ctrl.alu_src_b   = `SRC_B_FOUR;
            end
            DECODE: begin
                alu_ctrl.alu_src_a = `SRC_A_OLD_PC; // Branch target precomputed
                alu_ctrl.alu_src_b = `SRC_B_IMM;
            end
            MEMADR: begin
                alu_ctrl.alu_src_a    = `SRC_A_RS1;
                alu_ctrl.alu_src_b    = `SRC_B_IMM;
                mem_ctrl.save_address = 1'b1;
            end
            MEMREAD: begin
                mem_ctrl.memory_read = 1'b1;
                mem_ctrl.lord        = `ADDR_SAVED;
            end
            MEMWB: begin
                wb_ctrl.reg_write     = 1'b1;
                wb_ctrl.memory_to_reg = `WB_MEM_DATA;
            end
            MEMWRITE: begin
                mem_ctrl.memory_write = 1'b1;
                mem_ctrl.lord         = `ADDR_SAVED;
            end
            EXECUTER: begin
                alu_ctrl.alu_src_a = `SRC_A_RS1;
                alu_ctrl.aluop     = `ALUOP_FUNCT;
            end
            EXECUTEI: begin
                alu_ctrl.alu_src_a    = `SRC_A_RS1;
                alu_ctrl.alu_src_b    = `SRC_B_IMM;
                alu_ctrl.aluop        = `ALUOP_FUNCT;
                alu_ctrl.is_immediate = 1'b1;
            end
            ALUWB: begin
                wb_ctrl.reg_write = 1'b1;
            end
            // Target from DECODE goes to the PC while the ALU forms the link value
            JAL: begin
                alu_ctrl.alu_src_a = `SRC_A_OLD_PC;
                alu_ctrl.alu_src_b = `SRC_B_FOUR;
                pc_ctrl.pc_write   = 1'b1;
                pc_ctrl.pc_source  = 1'b1;
            end
            BRANCH: begin
                alu_ctrl.alu_src_a    = `SRC_A_RS1;
                alu_ctrl.aluop        = `ALUOP_BRANCH;
                pc_ctrl.pc_write_cond = 1'b1;
                pc_ctrl.pc_source     = 1'b1;
            end
            JALR_PC: begin
                alu_ctrl.alu_src_a = `SRC_A_RS1;
                alu_ctrl.alu_src_b = `SRC_B_IMM;
            end
            JALR: begin
                alu_ctrl.alu_src_a    = `SRC_A_OLD_PC;
                alu_ctrl.alu_src_b    = `SRC_B_FOUR;
                pc_ctrl.pc_write      = 1'b1;
                pc_ctrl.pc_source     = 1'b1;
                alu_ctrl.is_immediate = 1'b1;
            end
            AUIPC: begin
                alu_ctrl.alu_src_a = `SRC_A_OLD_PC;
                alu_ctrl.alu_src_b = `SRC_B_IMM;
            end
            LUI: begin
                alu_ctrl.alu_src_a = `SRC_A_ZERO; // 0 + upper immediate
                alu_ctrl.alu_src_b = `SRC_B_IMM;
            end
            EXECUTECSR: begin
                wb_ctrl.reg_write        = 1'b1;
                wb_ctrl.memory_to_reg    = `WB_CSR_DATA;
                wb_ctrl.csr_write_enable = 1'b1;
            end
            default: begin
                mem_ctrl.memory_read = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/opcode_decoder.sv ====
`timescale 1ns/1ps

`include "control_unit_settings.svh"

module opcode_decoder (
    input  control_unit_pkg::opcode_t      instruction_opcode,
    output control_unit_pkg::instr_class_t instr_class
);

    import control_unit_pkg::*;

    // Pure lookup on the major opcode while the funct fields are left to the ALU control
    always_comb begin
        case (instruction_opcode)
            `OP_LOAD: begin
                instr_class = CLASS_LOAD;
            end
            `OP_STORE: begin
                instr_class = CLASS_STORE;
            end
            `OP_RTYPE: begin
                instr_class = CLASS_RTYPE;
            end
            `OP_ITYPE: begin
                instr_class = CLASS_ITYPE;
            end
            `OP_JAL: begin
                instr_class = CLASS_JAL;
            end
            `OP_BRANCH: begin
                instr_class = CLASS_BRANCH;
            end
            `OP_JALR: begin
                instr_class = CLASS_JALR;
            end
            `OP_AUIPC: begin
                instr_class = CLASS_AUIPC;
            end
            `OP_LUI: begin
                instr_class = CLASS_LUI;
            end
            `OP_SYSTEM: begin
                instr_class = CLASS_CSR;
            end
            default: begin
                instr_class = CLASS_ILLEGAL; // Sends the machine back to fetch
            end
        endcase
    end

endmodule

// ==== src/state_sequencer.sv ====
`timescale 1ns/1ps

module state_sequencer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           memory_response,
    input  control_unit_pkg::instr_class_t instr_class,
    output control_unit_pkg::cu_state_t    state
);

    import control_unit_pkg::*;

    cu_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = FETCH;
        case (state)
            FETCH: begin
                if (memory_response) begin
                    next_state = VALIDATE_FETCH;
                end else begin
                    next_state = FETCH; // Wait for the instruction word
                end
            end
            VALIDATE_FETCH: begin
                next_state = DECODE;
            end
            // The instruction register is loaded by now, so the class is valid
            DECODE: begin
                case (instr_class)
                    CLASS_LOAD, CLASS_STORE: begin
                        next_state = MEMADR;
                    end
                    CLASS_RTYPE: begin
                        next_state = EXECUTER;
                    end
                    CLASS_ITYPE: begin
                        next_state = EXECUTEI;
                    end
                    CLASS_JAL: begin
                        next_state = JAL;
                    end
                    CLASS_BRANCH: begin
                        next_state = BRANCH;
                    end
                    CLASS_JALR: begin
                        next_state = JALR_PC;
                    end
                    CLASS_AUIPC: begin
                        next_state = AUIPC;
                    end
                    CLASS_LUI: begin
                        next_state = LUI;
                    end
                    CLASS_CSR: begin
                        next_state = EXECUTECSR;
                    end
                    default: begin
                        next_state = FETCH; // Unknown opcode is skipped
                    end
                endcase
            end
            MEMADR: begin
                if (instr_class == CLASS_STORE) begin
                    next_state = MEMWRITE;
                end else begin
                    next_state = MEMREAD;
                end
            end
            MEMREAD: begin
                if (memory_response) begin
                    next_state = MEMWB;
                end else begin
                    next_state = MEMREAD;
                end
            end
            MEMWRITE: begin
                if (memory_response) begin
                    next_state = FETCH;
                end else begin
                    next_state = MEMWRITE;
                end
            end
            EXECUTER, EXECUTEI, JAL, JALR, AUIPC, LUI: begin
                next_state = ALUWB;
            end
            JALR_PC: begin
                next_state = JALR; // Target is computed and the link address comes next
            end
            MEMWB, ALUWB, BRANCH, EXECUTECSR: begin
                next_state = FETCH;
            end
            default: begin
                next_state = FETCH;
            end
        endcase
    end

endmodule

// ==== testbench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Expected control word per state built up field by field
task automatic build_expected(
    input  cu_state_t st,
    output pc_ctrl_t  pc,
    output mem_ctrl_t mem,
    output alu_ctrl_t alu,
    output wb_ctrl_t  wb
);
    pc  = '0;
    mem = '0;
    alu = '0;
    wb  = '0;
    pc.pc_write      = st inside {VALIDATE_FETCH, JAL, JALR};
    pc.pc_write_cond = (st == BRANCH);
    pc.pc_source     = st inside {JAL, BRANCH, JALR};
    mem.memory_read  = st inside {FETCH, VALIDATE_FETCH, MEMREAD};
    mem.memory_write = (st == MEMWRITE);
    mem.ir_write     = (st == VALIDATE_FETCH);
    mem.save_address = (st == MEMADR);
    mem.lord         = (st inside {MEMREAD, MEMWRITE}) ? `ADDR_SAVED : `ADDR_PC;
    alu.alu_src_a    = (st inside {MEMADR, EXECUTER, EXECUTEI, BRANCH, JALR_PC}) ? `SRC_A_RS1 :
                       (st inside {DECODE, JAL, JALR, AUIPC}) ? `SRC_A_OLD_PC :
                       (st == LUI) ? `SRC_A_ZERO : `SRC_A_PC;
    alu.alu_src_b    = (st inside {DECODE, MEMADR, EXECUTEI, JALR_PC, AUIPC, LUI}) ? `SRC_B_IMM :
                       (st inside {VALIDATE_FETCH, JAL, JALR}) ? `SRC_B_FOUR : `SRC_B_RS2;
    alu.aluop        = (st inside {EXECUTER, EXECUTEI}) ? `ALUOP_FUNCT :
                       (st == BRANCH) ? `ALUOP_BRANCH : `ALUOP_ADD;
    alu.is_immediate = st inside {EXECUTEI, JALR};
    wb.reg_write     = st inside {MEMWB, ALUWB, EXECUTECSR};
    wb.memory_to_reg = (st == MEMWB) ? `WB_MEM_DATA :
                       (st == EXECUTECSR) ? `WB_CSR_DATA : `WB_ALU_OUT;
    wb.csr_write_enable = (st == EXECUTECSR);
endtask

task automatic pc_compare(input pc_ctrl_t actual, input pc_ctrl_t expected, input string step);
    check_count++;
    if (actual !== expected) begin
        $display("[FAIL] pc_ctrl = 0x%h, expected 0x%h in %s", actual, expected, step);
        error_count++;
    end
endtask

task automatic mem_compare(input mem_ctrl_t actual, input mem_ctrl_t expected, input string step);
    check_count++;
    if (actual !== expected) begin
        $display("[FAIL] mem_ctrl = 0x%h, expected 0x%h in %s", actual, expected, step);
        error_count++;
    end
endtask

task automatic alu_compare(input alu_ctrl_t actual, input alu_ctrl_t expected, input string step);
    check_count++;
    if (actual !== expected) begin
        $display("[FAIL] alu_ctrl = 0x%h, expected 0x%h in %s", actual, expected, step);
        error_count++;
    end
endtask

task automatic wb_compare(input wb_ctrl_t actual, input wb_ctrl_t expected, input string step);
    check_count++;
    if (actual !== expected) begin
        $display("[FAIL] wb_ctrl = 0x%h, expected 0x%h in %s", actual, expected, step);
        error_count++;
    end
endtask

`endif

// ==== testbench/tb_control_unit.sv ====
`timescale 1ns/1ps

`include "control_unit_settings.svh"

module tb_control_unit;

    import control_unit_pkg::*;

    localparam int RESET_CYCLES = 3;
    localparam int MAX_WAIT     = 3;
    localparam int NUM_INSTR    = 14;
    // A load with both memory waits at their longest is the worst case
    localparam int WORST_INSTR  = (MAX_WAIT + 1) + 2 + (MAX_WAIT + 3);
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_INSTR * WORST_INSTR + 20;

    logic        clk;
    logic        reset;
    logic        memory_response;
    opcode_t     instruction_opcode;
    pc_ctrl_t    pc_ctrl;
    mem_ctrl_t   mem_ctrl;
    alu_ctrl_t   alu_ctrl;
    wb_ctrl_t    wb_ctrl;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state = 32'h5317;

    `include "tb_checks.svh"

    control_unit uut (
        .clk                (clk),
        .reset              (reset),
        .memory_response    (memory_response),
        .instruction_opcode (instruction_opcode),
        .pc_ctrl            (pc_ctrl),
        .mem_ctrl           (mem_ctrl),
        .alu_ctrl           (alu_ctrl),
        .wb_ctrl            (wb_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic int next_wait();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[17:16]); // 0 to MAX_WAIT cycles
    endfunction

    task automatic expect_state(input cu_state_t st);
        pc_ctrl_t  exp_pc;
        mem_ctrl_t exp_mem;
        alu_ctrl_t exp_alu;
        wb_ctrl_t  exp_wb;
        build_expected(st, exp_pc, exp_mem, exp_alu, exp_wb);
        pc_compare(pc_ctrl, exp_pc, st.name());
        mem_compare(mem_ctrl, exp_mem, st.name());
        alu_compare(alu_ctrl, exp_alu, st.name());
        wb_compare(wb_ctrl, exp_wb, st.name());
    endtask

    task automatic advance();
        @(posedge clk);
        #10; // Inputs change and outputs are sampled away from the edge
    endtask

    task automatic advance_and_expect(input cu_state_t st);
        advance();
        expect_state(st);
    endtask

    // Response held low for a random time, then one high pulse
    task automatic memory_wait(input cu_state_t wait_state);
        int waits;
        waits = next_wait();
        repeat (waits) begin
            advance_and_expect(wait_state);
        end
        memory_response = 1'b1;
        advance();
        memory_response = 1'b0;
    endtask

    task automatic fetch_instruction(input opcode_t op);
        instruction_opcode = op;
        expect_state(FETCH);
        memory_wait(FETCH);
        expect_state(VALIDATE_FETCH);
        advance_and_expect(DECODE);
    endtask

    task automatic load_sequence();
        fetch_instruction(`OP_LOAD);
        advance_and_expect(MEMADR);
        advance_and_expect(MEMREAD);
        memory_wait(MEMREAD);
        expect_state(MEMWB);
        advance_and_expect(FETCH);
    endtask

    task automatic store_sequence();
        fetch_instruction(`OP_STORE);
        advance_and_expect(MEMADR);
        advance_and_expect(MEMWRITE);
        memory_wait(MEMWRITE);
        expect_state(FETCH);
    endtask

    task automatic alu_sequence(input opcode_t op, input cu_state_t exec_state);
        fetch_instruction(op);
        advance_and_expect(exec_state);
        advance_and_expect(ALUWB);
        advance_and_expect(FETCH);
    endtask

    task automatic jalr_sequence();
        fetch_instruction(`OP_JALR);
        advance_and_expect(JALR_PC);
        advance_and_expect(JALR);
        advance_and_expect(ALUWB);
        advance_and_expect(FETCH);
    endtask

    task automatic single_step_sequence(input opcode_t op, input cu_state_t exec_state);
        fetch_instruction(op);
        advance_and_expect(exec_state);
        advance_and_expect(FETCH);
    endtask

    task automatic illegal_sequence(input opcode_t op);
        fetch_instruction(op);
        advance_and_expect(FETCH); // DECODE falls straight back to fetch
    endtask

    initial begin
        reset = 1'b1;
        memory_response = 1'b0;
        instruction_opcode = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        reset = 1'b0;
        load_sequence();
        store_sequence();
        alu_sequence(`OP_RTYPE, EXECUTER);
        alu_sequence(`OP_ITYPE, EXECUTEI);
        alu_sequence(`OP_JAL, JAL);
        alu_sequence(`OP_AUIPC, AUIPC);
        alu_sequence(`OP_LUI, LUI);
        jalr_sequence();
        single_step_sequence(`OP_BRANCH, BRANCH);
        single_step_sequence(`OP_SYSTEM, EXECUTECSR);
        illegal_sequence(7'b1111111);
        illegal_sequence(7'b0000000);
        load_sequence();
        store_sequence();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
